// ==== verilog.f ====
+incdir+rtl
rtl/fir_pkg.sv
rtl/coef_bank.sv
rtl/shift_reg.sv
rtl/fir_filter.sv
rtl/out_scaler.sv
rtl/fir_subsystem.sv
verif/fir_subsystem_assert.sv
verif/fir_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: fir_subsystem

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fir_pkg.sv
      - rtl/coef_bank.sv
      - rtl/shift_reg.sv
      - rtl/fir_filter.sv
      - rtl/out_scaler.sv
      - rtl/fir_subsystem.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/fir_subsystem_assert.sv
      - verif/fir_subsystem_tb.sv

// ==== verif/fir_subsystem_tb.sv ====
/*
 * Directed testbench for the FIR subsystem, checked against a sample-accurate model.
 * Compile with verilog.f, top module fir_subsystem_tb.
 */
`timescale 1ns/100ps
`default_nettype none

`include "fir_defines.svh"

module fir_subsystem_tb;

    import fir_pkg::*;

    localparam int CH_NUM      = `FIR_CH_NUM;
    localparam int TAP_NUM     = `FIR_TAP_NUM;
    localparam int SHIFT       = `FIR_OUT_SHIFT;
    localparam int LATENCY     = 7;
    localparam int TEST_CYCLES = 1100;            // rough sum over all five tests
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    localparam sample_t S_MAX = sample_t'((1 << (`FIR_DATA_WIDTH - 1)) - 1);
    localparam sample_t S_MIN = sample_t'(-(1 << (`FIR_DATA_WIDTH - 1)));
    localparam coef_t   C_MAX = coef_t'((1 << (`FIR_COEF_WIDTH - 1)) - 1);

    logic         clk_i;
    logic         rst_i;
    coef_wr_t     coef_wr;
    sample_beat_t beat_in;
    out_beat_t    beat_out;

    int unsigned  cycle;
    int unsigned  out_count;
    logic [15:0]  lfsr_state;

    sample_t      hist [CH_NUM][TAP_NUM];   // model delay line, index 0 newest
    coef_t        coef_m [TAP_NUM];
    out_beat_t    exp_q [$];
    int unsigned  issue_q [$];              // cycle each beat was driven

    fir_subsystem i_fir_subsystem (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .coef_wr_i(coef_wr),
        .beat_i   (beat_in),
        .beat_o   (beat_out)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    // outputs are stable around the falling edge
    always @(negedge clk_i) begin
        if (!rst_i && beat_out.valid === 1'b1) begin
            check_output();
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic compare_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            $display("Error %s: expected 0x%h, got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_sat(input string name, input logic [CH_NUM-1:0] exp,
                               input logic [CH_NUM-1:0] act);
        if (act !== exp) begin
            $display("Error %s: expected 0x%h, got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Error %s: expected 0x%h, got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_output();
        out_beat_t   exp;
        int unsigned issued;
        if (exp_q.size() == 0) begin
            $display("output beat at cycle %0d with no input beat waiting for it", cycle);
            abort_run();
        end else begin
            exp = exp_q.pop_front();
            issued = issue_q.pop_front();
            compare_latency("beat_o latency", LATENCY, cycle - issued);
            for (int ch = 0; ch < CH_NUM; ch++) begin
                compare_sample($sformatf("beat_o.data[%0d]", ch), exp.data[ch],
                               beat_out.data[ch]);
            end
            compare_sat("beat_o.sat", exp.sat, beat_out.sat);
            out_count++;
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic sample_beat_t random_beat();
        sample_beat_t b;
        b = '0;
        for (int ch = 0; ch < CH_NUM; ch++) begin
            b.data[ch] = sample_t'(take_bits(`FIR_DATA_WIDTH));
        end
        return b;
    endfunction

    // round half up, arithmetic shift, clamp to sample range
    function automatic void scale_acc(input longint acc, output sample_t data, output logic sat);
        longint v;
        v = (acc + (64'sd1 <<< (SHIFT - 1))) >>> SHIFT;
        sat = 1'b1;
        if (v > longint'(S_MAX)) begin
            data = S_MAX;
        end else if (v < longint'(S_MIN)) begin
            data = S_MIN;
        end else begin
            data = sample_t'(v);
            sat = 1'b0;
        end
    endfunction

    function automatic out_beat_t model_step(input sample_beat_t b);
        out_beat_t res;
        longint    acc;
        sample_t   d;
        logic      s;
        res = '0;
        res.valid = 1'b1;
        for (int ch = 0; ch < CH_NUM; ch++) begin
            for (int t = TAP_NUM - 1; t > 0; t--) begin
                hist[ch][t] = hist[ch][t-1];
            end
            hist[ch][0] = b.data[ch];
            acc = 0;
            for (int t = 0; t < TAP_NUM; t++) begin
                acc += longint'(hist[ch][t]) * longint'(coef_m[t]);
            end
            scale_acc(acc, d, s);
            res.data[ch] = d;
            res.sat[ch] = s;
        end
        return res;
    endfunction

    task automatic write_coef(input coef_addr_t addr, input coef_t data);
        @(posedge clk_i);
        #1;
        coef_wr.wr   = 1'b1;
        coef_wr.addr = addr;
        coef_wr.data = data;
        coef_m[addr] = data;
        @(posedge clk_i);
        #1;
        coef_wr.wr = 1'b0;
    endtask

    // drives one valid beat, the model always advances
    task automatic send_beat(input sample_beat_t b, input logic use_given,
                             input out_beat_t given);
        out_beat_t exp;
        @(posedge clk_i);
        #1;
        beat_in.valid = 1'b1;
        beat_in.data  = b.data;
        exp = model_step(b);
        if (use_given) begin
            exp = given;
        end
        exp_q.push_back(exp);
        issue_q.push_back(cycle);
    endtask

    task automatic idle(input int n);
        sample_beat_t junk;
        for (int i = 0; i < n; i++) begin
            @(posedge clk_i);
            #1;
            junk = random_beat();
            beat_in.valid = 1'b0;
            beat_in.data  = junk.data;   // junk the filter must skip
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) begin
            idle(1);
        end
        idle(2);
    endtask

    task automatic test_reset_zero();
        out_beat_t zero;
        zero = '0;
        zero.valid = 1'b1;
        for (int i = 0; i < 16; i++) begin
            send_beat(random_beat(), 1'b1, zero);
        end
        drain();
    endtask

    task automatic test_impulse();
        sample_beat_t quiet;
        sample_beat_t pulse;
        out_beat_t    exp;
        sample_t      d;
        logic         s;
        quiet = '0;
        pulse = '0;
        for (int ch = 0; ch < CH_NUM; ch++) begin
            pulse.data[ch] = S_MAX;
        end
        for (int i = 0; i < TAP_NUM; i++) begin
            send_beat(quiet, 1'b0, exp);   // flush old history
        end
        drain();
        for (int t = 0; t < TAP_NUM; t++) begin
            write_coef(coef_addr_t'(t),
                       coef_t'(((t % 2) != 0) ? -(t + 1) * 13107 : (t + 1) * 13107));
        end
        for (int k = 0; k <= TAP_NUM; k++) begin
            exp = '0;
            exp.valid = 1'b1;
            if (k < TAP_NUM) begin
                scale_acc(longint'(S_MAX) * longint'(coef_m[k]), d, s);
                for (int ch = 0; ch < CH_NUM; ch++) begin
                    exp.data[ch] = d;
                    exp.sat[ch] = s;
                end
            end
            send_beat((k == 0) ? pulse : quiet, 1'b1, exp);
        end
        drain();
    endtask

    task automatic test_latency();
        out_beat_t   unused;
        int unsigned start;
        unused = '0;
        start = out_count;
        for (int i = 0; i < 6; i++) begin
            send_beat(random_beat(), 1'b0, unused);
            idle(LATENCY + 1);   // output due at the falling edge of the 7th cycle
            if (out_count - start != i + 1) begin
                $display("latency test: output beat %0d did not arrive within %0d cycles",
                         i, LATENCY);
                abort_run();
            end
            idle(int'(take_bits(3)));   // one beat in flight at a time
        end
        drain();
    endtask

    task automatic test_random_stream();
        out_beat_t unused;
        unused = '0;
        for (int t = 0; t < TAP_NUM; t++) begin
            write_coef(coef_addr_t'(t), coef_t'(take_bits(`FIR_COEF_WIDTH)));
        end
        for (int i = 0; i < 200; i++) begin
            send_beat(random_beat(), 1'b0, unused);
            idle(int'(take_bits(2)));
        end
        drain();
    endtask

    task automatic test_saturation();
        sample_beat_t b;
        out_beat_t    clamp;
        b = '0;
        for (int t = 0; t < TAP_NUM; t++) begin
            write_coef(coef_addr_t'(t), C_MAX);
        end
        for (int sgn = 0; sgn < 2; sgn++) begin
            clamp = '0;
            clamp.valid = 1'b1;
            clamp.sat = '1;
            for (int ch = 0; ch < CH_NUM; ch++) begin
                b.data[ch] = (sgn == 0) ? S_MAX : S_MIN;
                clamp.data[ch] = (sgn == 0) ? S_MAX : S_MIN;
            end
            // last beat has a full line of one sign
            for (int i = 0; i < TAP_NUM; i++) begin
                send_beat(b, (i == TAP_NUM - 1), clamp);
            end
        end
        drain();
    endtask

    initial begin
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        coef_wr    = '0;
        beat_in    = '0;
        cycle      = 0;
        out_count  = 0;
        lfsr_state = 16'd20819;
        for (int t = 0; t < TAP_NUM; t++) begin
            coef_m[t] = '0;
            for (int ch = 0; ch < CH_NUM; ch++) begin
                hist[ch][t] = '0;
            end
        end
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        test_reset_zero();
        test_impulse();
        test_latency();
        test_random_stream();
        test_saturation();

        if (exp_q.size() != 0) begin
            $display("%0d expected output beats never arrived", exp_q.size());
            abort_run();
        end else if (i_fir_subsystem.i_fir_subsystem_assert.fail_count != 0) begin
            $display("port assertions failed during the run");
            abort_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verif/fir_subsystem_assert.sv ====
/*
 * Port-level checks for the FIR subsystem, bound into every fir_subsystem instance.
 */
`timescale 1ns/100ps
`default_nettype none

`include "fir_defines.svh"

module fir_subsystem_assert (
    input logic                  clk_i,
    input logic                  rst_i,
    input fir_pkg::sample_beat_t beat_i,
    input fir_pkg::out_beat_t    beat_o
);

    import fir_pkg::*;

    localparam int      LATENCY = 7;
    localparam sample_t S_MAX   = sample_t'((1 << (`FIR_DATA_WIDTH - 1)) - 1);
    localparam sample_t S_MIN   = sample_t'(-(1 << (`FIR_DATA_WIDTH - 1)));

    int unsigned fail_count = 0;
    int unsigned run_cnt;   // edges out of reset, stops at LATENCY

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run_cnt <= 0;
        end else if (run_cnt < LATENCY) begin
            run_cnt <= run_cnt + 1;
        end
    end

    valid_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !beat_o.valid)
        else begin
            $error("beat_o.valid high in the cycle after reset");
            fail_count++;
        end

    // only once the whole valid pipeline has left reset
    valid_follows_input: assert property (@(posedge clk_i) disable iff (rst_i)
        (run_cnt == LATENCY) |-> (beat_o.valid == $past(beat_i.valid, LATENCY)))
        else begin
            $error("beat_o.valid does not follow beat_i.valid by %0d cycles", LATENCY);
            fail_count++;
        end

    for (genvar ch = 0; ch < `FIR_CH_NUM; ch++) begin : g_ch
        sat_only_clamped: assert property (@(posedge clk_i) disable iff (rst_i)
            (beat_o.valid && beat_o.sat[ch]) |->
            ((beat_o.data[ch] == S_MAX) || (beat_o.data[ch] == S_MIN)))
            else begin
                $error("sat set on channel %0d without a clamped value", ch);
                fail_count++;
            end
    end

endmodule

bind fir_subsystem fir_subsystem_assert i_fir_subsystem_assert (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .beat_i(beat_i),
    .beat_o(beat_o)
);

`default_nettype wire

// ==== rtl/fir_subsystem.sv ====
/*
 * Top of the FIR subsystem: coefficient bank, filter core and output scaler.
 * beat_o follows beat_i by 7 cycles, no back-pressure anywhere.
 */
`timescale 1ns/100ps
`default_nettype none

module fir_subsystem (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  fir_pkg::coef_wr_t      coef_wr_i,
    input  fir_pkg::sample_beat_t  beat_i,
    output fir_pkg::out_beat_t     beat_o
);

    import fir_pkg::*;

    coef_vec_t  coefs;
    acc_beat_t  acc_beat;

    coef_bank i_coef_bank (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .wr_i   (coef_wr_i),
        .coefs_o(coefs)
    );

    // coefficients feed the multipliers directly, no sync to the stream
    fir_filter i_fir_filter (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .beat_i (beat_i),
        .coefs_i(coefs),
        .beat_o (acc_beat)
    );

    out_scaler i_out_scaler (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .beat_i(acc_beat),
        .beat_o(beat_o)
    );

endmodule

`default_nettype wire

// ==== rtl/out_scaler.sv ====
/*
 * Brings the wide FIR accumulator back to sample width:
 * round half up, arithmetic shift, saturate and flag clipping per channel.
 */
`timescale 1ns/100ps
`default_nettype none

`include "fir_defines.svh"

module out_scaler (
    input  logic                clk_i,
    input  logic                rst_i,
    input  fir_pkg::acc_beat_t  beat_i,
    output fir_pkg::out_beat_t  beat_o
);

    import fir_pkg::*;

    localparam int CH_NUM = `FIR_CH_NUM;
    localparam int SHIFT  = `FIR_OUT_SHIFT;

    localparam acc_t    ROUND = acc_t'(1) <<< (SHIFT - 1); // half an output LSB
    localparam sample_t S_MAX = {1'b0, {(`FIR_DATA_WIDTH - 1){1'b1}}};
    localparam sample_t S_MIN = {1'b1, {(`FIR_DATA_WIDTH - 1){1'b0}}};

    sample_t [CH_NUM-1:0] data_d;
    logic [CH_NUM-1:0]    sat_d;

    for (genvar ch = 0; ch < CH_NUM; ch++) begin : g_ch
        acc_t rounded;
        acc_t shifted;
        logic over;
        logic under;

        assign rounded = $signed(beat_i.acc[ch]) + ROUND;
        assign shifted = rounded >>> SHIFT;

        // range check against sign-extended limits
        assign over  = shifted > acc_t'(S_MAX);
        assign under = shifted < acc_t'(S_MIN);

        assign data_d[ch] = over  ? S_MAX :
                            under ? S_MIN : sample_t'(shifted);
        assign sat_d[ch]  = over | under;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            beat_o.valid <= 1'b0;
        end else begin
            beat_o.valid <= beat_i.valid;
        end
        beat_o.data <= data_d;
        beat_o.sat  <= sat_d;
    end

endmodule

`default_nettype wire

// ==== rtl/fir_filter.sv ====
/*
 * Multichannel FIR core: per-channel tapped delay line, a multiplier per tap
 * and a registered binary adder tree. Output comes 6 edges after the input beat.
 */
`timescale 1ns/100ps
`default_nettype none

`include "fir_defines.svh"

module fir_filter (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  fir_pkg::sample_beat_t  beat_i,
    input  fir_pkg::coef_vec_t     coefs_i,
    output fir_pkg::acc_beat_t     beat_o
);

    import fir_pkg::*;

    localparam int CH_NUM     = `FIR_CH_NUM;
    localparam int TAP_NUM    = `FIR_TAP_NUM;
    localparam int TREE_DEPTH = `FIR_TREE_DEPTH;

    // delay line + multiplier + tree levels, output register comes on top
    localparam int VALID_DELAY = TREE_DEPTH + 2;

    if ((TAP_NUM < 2) || ((TAP_NUM & (TAP_NUM - 1)) != 0)) begin : g_tap_num_err
        $error("FIR_TAP_NUM must be a power of two");
    end

    if (TREE_DEPTH != $clog2(TAP_NUM)) begin : g_tree_depth_err
        $error("FIR_TREE_DEPTH must be log2 of FIR_TAP_NUM");
    end

    logic                 valid_d;
    acc_t [CH_NUM-1:0]    tree_out;

    shift_reg #(
        .WIDTH(1),
        .DELAY(VALID_DELAY)
    ) i_valid_dly (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .data_i(beat_i.valid),
        .data_o(valid_d)
    );

    for (genvar ch = 0; ch < CH_NUM; ch++) begin : g_ch
        sample_t [TAP_NUM-1:0] taps;

        // moves only on valid beats, so gaps in the stream are skipped
        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                taps <= '0;
            end else if (beat_i.valid) begin
                taps[0] <= beat_i.data[ch];
                for (int t = 1; t < TAP_NUM; t++) begin
                    taps[t] <= taps[t-1];
                end
            end
        end

        // level 0 holds the products, each next level halves the count
        for (genvar lvl = 0; lvl <= TREE_DEPTH; lvl++) begin : g_lvl
            localparam int N = TAP_NUM >> lvl;

            acc_t [N-1:0] sum;

            if (lvl == 0) begin : g_mult
                always_ff @(posedge clk_i) begin
                    for (int t = 0; t < N; t++) begin
                        sum[t] <= $signed(taps[t]) * $signed(coefs_i[t]);
                    end
                end
            end else begin : g_add
                always_ff @(posedge clk_i) begin
                    for (int i = 0; i < N; i++) begin
                        sum[i] <= $signed(g_lvl[lvl-1].sum[2*i]) +
                                  $signed(g_lvl[lvl-1].sum[2*i+1]);
                    end
                end
            end
        end

        assign tree_out[ch] = g_lvl[TREE_DEPTH].sum[0];
    end

    // output register, valid realigned with the tree result
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            beat_o.valid <= 1'b0;
        end else begin
            beat_o.valid <= valid_d;
        end
        beat_o.acc <= tree_out;
    end

endmodule

`default_nettype wire

// ==== rtl/shift_reg.sv ====
/*
 * Fixed-depth register chain with reset.
 * Used to carry a control bit alongside a datapath pipeline.
 */
`timescale 1ns/100ps
`default_nettype none

module shift_reg #(
    parameter int WIDTH = 1,
    parameter int DELAY = 1
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [WIDTH-1:0] data_i,
    output logic [WIDTH-1:0] data_o
);

    if (DELAY < 1) begin : g_delay_err
        $error("shift_reg needs DELAY of at least 1");
    end

    logic [DELAY-1:0][WIDTH-1:0] stage_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage_q <= '0;
        end else begin
            stage_q[0] <= data_i;
            for (int i = 1; i < DELAY; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign data_o = stage_q[DELAY-1]; // oldest stage

endmodule

`default_nettype wire

// ==== rtl/coef_bank.sv ====
/*
 * Coefficient register file for the FIR filter.
 * Written one tap at a time by the host, read by all multipliers in parallel.
 */
`timescale 1ns/100ps
`default_nettype none

module coef_bank (
    input  logic                clk_i,
    input  logic                rst_i,
    input  fir_pkg::coef_wr_t   wr_i,
    output fir_pkg::coef_vec_t  coefs_o
);

    import fir_pkg::*;

    coef_vec_t coefs_q;

    // all taps zero after reset, so the filter outputs zero until loaded
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            coefs_q <= '0;
        end else if (wr_i.wr) begin
            coefs_q[wr_i.addr] <= wr_i.data;
        end
    end

    assign coefs_o = coefs_q; // visible one cycle after the strobe

endmodule

`default_nettype wire

// ==== rtl/fir_pkg.sv ====
/*
 * Vector types and beat structs shared by the FIR subsystem and its testbench.
 */
`default_nettype none

`include "fir_defines.svh"

package fir_pkg;

    typedef logic signed [`FIR_DATA_WIDTH-1:0] sample_t;
    typedef logic signed [`FIR_COEF_WIDTH-1:0] coef_t;
    typedef logic signed [`FIR_ACC_WIDTH-1:0]  acc_t;
    typedef logic [$clog2(`FIR_TAP_NUM)-1:0]   coef_addr_t;

    // host write into the coefficient bank
    typedef struct packed {
        logic       wr;
        coef_addr_t addr;
        coef_t      data;
    } coef_wr_t;

    typedef coef_t [`FIR_TAP_NUM-1:0] coef_vec_t; // index 0 = newest-sample tap

    typedef struct packed {
        logic                         valid;
        sample_t [`FIR_CH_NUM-1:0]    data;
    } sample_beat_t;

    typedef struct packed {
        logic                         valid;
        acc_t [`FIR_CH_NUM-1:0]       acc;
    } acc_beat_t;

    typedef struct packed {
        logic                         valid;
        sample_t [`FIR_CH_NUM-1:0]    data;
        logic [`FIR_CH_NUM-1:0]       sat;   // clip flag per channel
    } out_beat_t;

endpackage

`default_nettype wire

// ==== rtl/fir_defines.svh ====
/*
 * Build-time sizing for the multichannel FIR subsystem.
 * Included by the package and by every module that needs a size.
 */
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// channels carried side by side in one beat
`define FIR_CH_NUM      2

`define FIR_DATA_WIDTH  16
`define FIR_COEF_WIDTH  18

// power of two only
`define FIR_TAP_NUM     8
`define FIR_TREE_DEPTH  3   // log2 of tap count

// one extra bit per tree level, so the sum cannot overflow
`define FIR_ACC_WIDTH   (`FIR_DATA_WIDTH + `FIR_COEF_WIDTH + `FIR_TREE_DEPTH)

// coefficients are signed Q1.17
`define FIR_OUT_SHIFT   17

`endif
